// File: build.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module tb_rv_core -f sim.f -o tb_rv_core
./obj_dir/tb_rv_core

// File: hw/alu.sv
// rv32i integer alu with the ten base operations
`timescale 1ns/10ps

module alu (
  input  rv_types_pkg::alu_op_t op,
  input  rv_types_pkg::word_t   a,
  input  rv_types_pkg::word_t   b,
  output rv_types_pkg::word_t   y
);

  logic [4:0] shamt;

  // shifts only look at the low five bits
  assign shamt = b[4:0];

  always_comb begin
    case (op)
      rv_types_pkg::ADD:  y = a + b;
      rv_types_pkg::SUB:  y = a - b;
      rv_types_pkg::AND:  y = a & b;
      rv_types_pkg::OR:   y = a | b;
      rv_types_pkg::XOR:  y = a ^ b;
      // set-less-than results are zero extended flags
      rv_types_pkg::SLT:  y = {31'd0, $signed(a) < $signed(b)};
      rv_types_pkg::SLTU: y = {31'd0, a < b};
      rv_types_pkg::SLL:  y = a << shamt;
      rv_types_pkg::SRL:  y = a >> shamt;
      rv_types_pkg::SRA:  y = $signed(a) >>> shamt;
      default:            y = a + b;
    endcase
  end

endmodule

// File: hw/control_unit.sv
// rv32i decoder producing the control struct and sign-extended immediates
`timescale 1ns/10ps
`include "rv_consts.svh"

module control_unit (
  input  rv_types_pkg::word_t instr,
  output rv_types_pkg::ctrl_t ctrl,
  output rv_types_pkg::word_t imm_i,
  output rv_types_pkg::word_t imm_s,
  output rv_types_pkg::word_t imm_b,
  output rv_types_pkg::word_t imm_u,
  output rv_types_pkg::word_t imm_j
);

  logic [6:0]            opcode;
  logic [2:0]            funct3;
  logic                  funct7_b5;
  rv_types_pkg::alu_op_t f3_op;

  assign opcode    = instr[6:0];
  assign funct3    = instr[14:12];
  // selects sub and sra
  assign funct7_b5 = instr[30];

  // immediates, sign bit always instr[31]
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'h000};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  // alu op from funct3, no subi in op-imm
  always_comb begin
    case (funct3)
      `RV_F3_ADD: begin
        f3_op = (opcode == `RV_OP_OP && funct7_b5) ? rv_types_pkg::SUB : rv_types_pkg::ADD;
      end
      `RV_F3_SLL:  f3_op = rv_types_pkg::SLL;
      `RV_F3_SLT:  f3_op = rv_types_pkg::SLT;
      `RV_F3_SLTU: f3_op = rv_types_pkg::SLTU;
      `RV_F3_XOR:  f3_op = rv_types_pkg::XOR;
      `RV_F3_SR:   f3_op = funct7_b5 ? rv_types_pkg::SRA : rv_types_pkg::SRL;
      `RV_F3_OR:   f3_op = rv_types_pkg::OR;
      default:     f3_op = rv_types_pkg::AND;
    endcase
  end

  always_comb begin
    // defaults describe a nop: no write, no access, no redirect
    ctrl.alu_op      = rv_types_pkg::ADD;
    ctrl.a_sel       = rv_types_pkg::A_RS1;
    ctrl.b_sel       = rv_types_pkg::B_RS2;
    ctrl.w_sel       = rv_types_pkg::W_ALU;
    ctrl.wen         = 1'b0;
    ctrl.dren        = 1'b0;
    ctrl.dwen        = 1'b0;
    ctrl.load_type   = rv_types_pkg::LW;
    ctrl.branch      = 1'b0;
    ctrl.branch_type = rv_types_pkg::BEQ;
    ctrl.jump        = 1'b0;
    ctrl.j_sel       = 1'b0;
    ctrl.halt        = 1'b0;
    ctrl.rs1         = instr[19:15];
    ctrl.rs2         = instr[24:20];
    ctrl.rd          = instr[11:7];
    if (instr == `RV_HALT_INSN) begin
      ctrl.halt = 1'b1;
    end else begin
      case (opcode)
        `RV_OP_LUI: begin
          ctrl.wen   = 1'b1;
          ctrl.w_sel = rv_types_pkg::W_IMMU;
        end
        `RV_OP_AUIPC: begin
          // pc + u immediate through the alu
          ctrl.wen   = 1'b1;
          ctrl.a_sel = rv_types_pkg::A_PC;
          ctrl.b_sel = rv_types_pkg::B_IMM;
        end
        `RV_OP_JAL, `RV_OP_JALR: begin
          ctrl.jump  = 1'b1;
          ctrl.j_sel = (opcode == `RV_OP_JAL);
          ctrl.wen   = 1'b1;
          ctrl.w_sel = rv_types_pkg::W_PC4;
        end
        `RV_OP_BRANCH: begin
          ctrl.branch = 1'b1;
          case (funct3)
            `RV_F3_BEQ:  ctrl.branch_type = rv_types_pkg::BEQ;
            `RV_F3_BNE:  ctrl.branch_type = rv_types_pkg::BNE;
            `RV_F3_BLT:  ctrl.branch_type = rv_types_pkg::BLT;
            `RV_F3_BGE:  ctrl.branch_type = rv_types_pkg::BGE;
            `RV_F3_BLTU: ctrl.branch_type = rv_types_pkg::BLTU;
            `RV_F3_BGEU: ctrl.branch_type = rv_types_pkg::BGEU;
            default:     ctrl.branch      = 1'b0;
          endcase
        end
        `RV_OP_LOAD: begin
          ctrl.dren  = 1'b1;
          ctrl.wen   = 1'b1;
          ctrl.b_sel = rv_types_pkg::B_IMM;
          ctrl.w_sel = rv_types_pkg::W_LOAD;
          case (funct3)
            `RV_F3_LB:  ctrl.load_type = rv_types_pkg::LB;
            `RV_F3_LH:  ctrl.load_type = rv_types_pkg::LH;
            `RV_F3_LW:  ctrl.load_type = rv_types_pkg::LW;
            `RV_F3_LBU: ctrl.load_type = rv_types_pkg::LBU;
            `RV_F3_LHU: ctrl.load_type = rv_types_pkg::LHU;
            default: begin
              ctrl.dren = 1'b0;
              ctrl.wen  = 1'b0;
            end
          endcase
        end
        `RV_OP_STORE: begin
          // load_type doubles as store size
          ctrl.dwen  = 1'b1;
          ctrl.b_sel = rv_types_pkg::B_IMM;
          case (funct3)
            `RV_F3_SB: ctrl.load_type = rv_types_pkg::LB;
            `RV_F3_SH: ctrl.load_type = rv_types_pkg::LH;
            `RV_F3_SW: ctrl.load_type = rv_types_pkg::LW;
            default:   ctrl.dwen      = 1'b0;
          endcase
        end
        `RV_OP_OPIMM: begin
          ctrl.wen    = 1'b1;
          ctrl.b_sel  = rv_types_pkg::B_IMM;
          ctrl.alu_op = f3_op;
        end
        `RV_OP_OP: begin
          ctrl.wen    = 1'b1;
          ctrl.alu_op = f3_op;
        end
        default: begin
          // unknown opcode stays a nop
          ctrl.wen = 1'b0;
        end
      endcase
    end
  end

endmodule

// File: hw/execute_stage.sv
// execute stage with decode, register file, alu, branch and jump resolution, lanes and halt
`timescale 1ns/10ps

module execute_stage (
  input  logic                CLK,
  input  logic                arst_n,
  fetch_execute_if.execute    fe,
  output rv_types_pkg::word_t dmem_addr,
  output rv_types_pkg::word_t dmem_wdata,
  output logic [3:0]          dmem_byte_en,
  output logic                dmem_ren,
  output logic                dmem_wen,
  input  rv_types_pkg::word_t dmem_rdata,
  input  logic                dmem_busy,
  output logic                halt,
  output logic                mal_fault
);

  rv_types_pkg::ctrl_t ctrl;
  rv_types_pkg::word_t imm_i, imm_s, imm_b, imm_u, imm_j;
  rv_types_pkg::word_t rs1_data, rs2_data;
  rv_types_pkg::word_t alu_a, alu_b, alu_y, alu_imm;
  rv_types_pkg::word_t jump_addr, wb_data, load_ext, lane_shift;
  logic [15:0]         lane_h;
  logic [1:0]          byte_off;
  logic                taken, misaligned, mal_access, mem_stall;
  logic                live, halt_now, halted_q, rf_wen;

  control_unit u_cu (
    .instr (fe.instr),
    .ctrl  (ctrl),
    .imm_i (imm_i),
    .imm_s (imm_s),
    .imm_b (imm_b),
    .imm_u (imm_u),
    .imm_j (imm_j)
  );

  reg_file u_rf (
    .CLK      (CLK),
    .arst_n   (arst_n),
    .rs1      (ctrl.rs1),
    .rs2      (ctrl.rs2),
    .rd       (ctrl.rd),
    .wen      (rf_wen),
    .wdata    (wb_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  alu u_alu (
    .op (ctrl.alu_op),
    .a  (alu_a),
    .b  (alu_b),
    .y  (alu_y)
  );

  // a real instruction that is not parked behind a halt
  assign live     = fe.valid & ~halted_q;
  assign halt_now = fe.valid & ctrl.halt;

  // stores use s-type, auipc uses u-type, everything else i-type
  assign alu_imm = ctrl.dwen ? imm_s :
                   (ctrl.a_sel == rv_types_pkg::A_PC) ? imm_u : imm_i;
  assign alu_a   = (ctrl.a_sel == rv_types_pkg::A_PC) ? fe.pc : rs1_data;
  assign alu_b   = (ctrl.b_sel == rv_types_pkg::B_IMM) ? alu_imm : rs2_data;

  // branch condition on the raw register values
  always_comb begin
    case (ctrl.branch_type)
      rv_types_pkg::BEQ:  taken = (rs1_data == rs2_data);
      rv_types_pkg::BNE:  taken = (rs1_data != rs2_data);
      rv_types_pkg::BLT:  taken = ($signed(rs1_data) < $signed(rs2_data));
      rv_types_pkg::BGE:  taken = ($signed(rs1_data) >= $signed(rs2_data));
      rv_types_pkg::BLTU: taken = (rs1_data < rs2_data);
      default:            taken = (rs1_data >= rs2_data);
    endcase
  end

  // jal is pc relative, jalr clears bit 0 of rs1 + imm
  assign jump_addr   = ctrl.j_sel ? (fe.pc + imm_j) : ((rs1_data + imm_i) & ~32'd1);
  assign fe.brj_addr = ctrl.jump ? jump_addr : (fe.pc + imm_b);
  // fetch always guesses not-taken, so every taken transfer redirects
  assign fe.redirect = live & (ctrl.jump | (ctrl.branch & taken));

  // byte lanes and alignment from size and address low bits
  assign byte_off = alu_y[1:0];
  always_comb begin
    case (ctrl.load_type)
      rv_types_pkg::LB, rv_types_pkg::LBU: begin
        dmem_byte_en = 4'b0001 << byte_off;
        misaligned   = 1'b0;
      end
      rv_types_pkg::LH, rv_types_pkg::LHU: begin
        dmem_byte_en = byte_off[1] ? 4'b1100 : 4'b0011;
        misaligned   = byte_off[0];
      end
      default: begin
        dmem_byte_en = 4'b1111;
        misaligned   = (byte_off != 2'b00);
      end
    endcase
  end

  // store data copied into every lane, byte_en picks the live one
  always_comb begin
    case (ctrl.load_type)
      rv_types_pkg::LB: dmem_wdata = {4{rs2_data[7:0]}};
      rv_types_pkg::LH: dmem_wdata = {2{rs2_data[15:0]}};
      default:          dmem_wdata = rs2_data;
    endcase
  end

  // a misaligned access never reaches the bus, so it cannot stall
  assign mal_access = live & (ctrl.dren | ctrl.dwen) & misaligned;
  assign mal_fault  = mal_access;
  assign dmem_addr  = alu_y;
  assign dmem_ren   = live & ctrl.dren & ~misaligned;
  assign dmem_wen   = live & ctrl.dwen & ~misaligned;
  assign mem_stall  = (dmem_ren | dmem_wen) & dmem_busy;
  // halt freezes fetch the same way busy does
  assign fe.stall   = mem_stall | halt;

  // pick the addressed lane, then extend
  assign lane_shift = dmem_rdata >> {byte_off, 3'b000};
  assign lane_h     = byte_off[1] ? dmem_rdata[31:16] : dmem_rdata[15:0];
  always_comb begin
    case (ctrl.load_type)
      rv_types_pkg::LB:  load_ext = {{24{lane_shift[7]}}, lane_shift[7:0]};
      rv_types_pkg::LBU: load_ext = {24'd0, lane_shift[7:0]};
      rv_types_pkg::LH:  load_ext = {{16{lane_h[15]}}, lane_h};
      rv_types_pkg::LHU: load_ext = {16'd0, lane_h};
      default:           load_ext = dmem_rdata;
    endcase
  end

  always_comb begin
    case (ctrl.w_sel)
      rv_types_pkg::W_LOAD: wb_data = load_ext;
      rv_types_pkg::W_PC4:  wb_data = fe.pc4;
      rv_types_pkg::W_IMMU: wb_data = imm_u;
      default:              wb_data = alu_y;
    endcase
  end

  // write lands at the end of the cycle the access completes
  assign rf_wen = live & ctrl.wen & ~mem_stall & ~mal_access;

  // sticky halt, the halt word also stays parked in the pipe register
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      halted_q <= 1'b0;
    end else if (halt_now) begin
      halted_q <= 1'b1;
    end
  end

  assign halt = halted_q | halt_now;

endmodule

// File: hw/fetch_execute_if.sv
// fetch to execute pipeline interface with fetch and execute modports
`timescale 1ns/10ps

interface fetch_execute_if;
  // pipeline register contents, owned by fetch
  rv_types_pkg::word_t instr;
  rv_types_pkg::word_t pc;
  rv_types_pkg::word_t pc4;
  logic                valid;
  // control fed back from execute
  rv_types_pkg::word_t brj_addr;
  logic                redirect;
  // busy back-pressure, also high once halted
  logic                stall;

  modport fetch (
    output instr, pc, pc4, valid,
    input  brj_addr, redirect, stall
  );

  modport execute (
    input  instr, pc, pc4, valid,
    output brj_addr, redirect, stall
  );
endinterface

// File: hw/fetch_stage.sv
// fetch stage with pc register, instruction request and fetch/execute register
`timescale 1ns/10ps
`include "rv_consts.svh"

module fetch_stage (
  input  logic                CLK,
  input  logic                arst_n,
  output rv_types_pkg::word_t imem_addr,
  input  rv_types_pkg::word_t imem_rdata,
  fetch_execute_if.fetch      fe
);

  rv_types_pkg::word_t pc_q;
  rv_types_pkg::word_t pc_plus4;
  rv_types_pkg::word_t pc_next;

  // static not-taken prediction, a redirect overrides it
  assign pc_plus4  = pc_q + 32'd4;
  assign pc_next   = fe.redirect ? fe.brj_addr : pc_plus4;
  // memory answers in the same cycle
  assign imem_addr = pc_q;

  // pc and valid bit
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      pc_q     <= `RV_RESET_PC;
      fe.valid <= 1'b0;
    end else if (!fe.stall) begin
      pc_q     <= pc_next;
      // the word fetched beside a taken branch is wrong path, so bubble it
      fe.valid <= !fe.redirect;
    end
  end

  // payload only, qualified by valid downstream
  always_ff @(posedge CLK) begin
    if (!fe.stall) begin
      fe.instr <= imem_rdata;
      fe.pc    <= pc_q;
      fe.pc4   <= pc_plus4;
    end
  end

endmodule

// File: hw/reg_file.sv
// 32-entry integer register file, x0 hard-wired, two read ports and one write port
`timescale 1ns/10ps

module reg_file (
  input  logic                   CLK,
  input  logic                   arst_n,
  input  rv_types_pkg::reg_idx_t rs1,
  input  rv_types_pkg::reg_idx_t rs2,
  input  rv_types_pkg::reg_idx_t rd,
  input  logic                   wen,
  input  rv_types_pkg::word_t    wdata,
  output rv_types_pkg::word_t    rs1_data,
  output rv_types_pkg::word_t    rs2_data
);

  // x1..x31 only, x0 has no storage
  rv_types_pkg::word_t regs [31:1];

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && rd != 5'd0) begin
      regs[rd] <= wdata;
    end
  end

  // combinational read sees a write only after the edge
  assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

// File: hw/rv_consts.svh
// opcode, funct3, halt word and reset pc defines for the rv32i core
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// major opcodes, instr[6:0]
`define RV_OP_LUI    7'b0110111
`define RV_OP_AUIPC  7'b0010111
`define RV_OP_JAL    7'b1101111
`define RV_OP_JALR   7'b1100111
`define RV_OP_BRANCH 7'b1100011
`define RV_OP_LOAD   7'b0000011
`define RV_OP_STORE  7'b0100011
`define RV_OP_OPIMM  7'b0010011
`define RV_OP_OP     7'b0110011

// branch funct3
`define RV_F3_BEQ  3'b000
`define RV_F3_BNE  3'b001
`define RV_F3_BLT  3'b100
`define RV_F3_BGE  3'b101
`define RV_F3_BLTU 3'b110
`define RV_F3_BGEU 3'b111

// load and store funct3
`define RV_F3_LB  3'b000
`define RV_F3_LH  3'b001
`define RV_F3_LW  3'b010
`define RV_F3_LBU 3'b100
`define RV_F3_LHU 3'b101
`define RV_F3_SB  3'b000
`define RV_F3_SH  3'b001
`define RV_F3_SW  3'b010

// alu funct3, shared by OP and OP-IMM
`define RV_F3_ADD  3'b000
`define RV_F3_SLL  3'b001
`define RV_F3_SLT  3'b010
`define RV_F3_SLTU 3'b011
`define RV_F3_XOR  3'b100
`define RV_F3_SR   3'b101
`define RV_F3_OR   3'b110
`define RV_F3_AND  3'b111

// all-ones word stops the core
`define RV_HALT_INSN 32'hffff_ffff
`define RV_RESET_PC  32'h0000_0000

`endif

// File: hw/rv_core_top.sv
// two-stage rv32i core top level wiring fetch and execute to the memory ports
`timescale 1ns/10ps

module rv_core_top (
  input  logic                CLK,
  input  logic                arst_n,
  output rv_types_pkg::word_t imem_addr,
  input  rv_types_pkg::word_t imem_rdata,
  output rv_types_pkg::word_t dmem_addr,
  output rv_types_pkg::word_t dmem_wdata,
  output logic [3:0]          dmem_byte_en,
  output logic                dmem_ren,
  output logic                dmem_wen,
  input  rv_types_pkg::word_t dmem_rdata,
  input  logic                dmem_busy,
  output logic                halt,
  output logic                mal_fault
);

  // pipeline register and feedback between the stages
  fetch_execute_if fe_if ();

  fetch_stage u_fetch (
    .CLK        (CLK),
    .arst_n     (arst_n),
    .imem_addr  (imem_addr),
    .imem_rdata (imem_rdata),
    .fe         (fe_if.fetch)
  );

  execute_stage u_execute (
    .CLK          (CLK),
    .arst_n       (arst_n),
    .fe           (fe_if.execute),
    .dmem_addr    (dmem_addr),
    .dmem_wdata   (dmem_wdata),
    .dmem_byte_en (dmem_byte_en),
    .dmem_ren     (dmem_ren),
    .dmem_wen     (dmem_wen),
    .dmem_rdata   (dmem_rdata),
    .dmem_busy    (dmem_busy),
    .halt         (halt),
    .mal_fault    (mal_fault)
  );

endmodule

// File: hw/rv_types_pkg.sv
// word, register index, control enums and decoded control struct for the core
package rv_types_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;

  typedef enum logic [3:0] {
    ADD,
    SUB,
    AND,
    OR,
    XOR,
    SLT,
    SLTU,
    SLL,
    SRL,
    SRA
  } alu_op_t;

  // also used as store size: LB byte, LH half, LW word
  typedef enum logic [2:0] {
    LB,
    LH,
    LW,
    LBU,
    LHU
  } load_type_t;

  typedef enum logic [2:0] {
    BEQ,
    BNE,
    BLT,
    BGE,
    BLTU,
    BGEU
  } branch_type_t;

  typedef enum logic {A_RS1, A_PC} a_sel_t;
  typedef enum logic {B_RS2, B_IMM} b_sel_t;
  typedef enum logic [1:0] {W_LOAD, W_PC4, W_IMMU, W_ALU} w_sel_t;

  typedef struct packed {
    alu_op_t      alu_op;
    a_sel_t       a_sel;
    b_sel_t       b_sel;
    w_sel_t       w_sel;
    logic         wen;
    logic         dren;
    logic         dwen;
    load_type_t   load_type;
    logic         branch;
    branch_type_t branch_type;
    logic         jump;
    // 1 for jal (pc relative), 0 for jalr
    logic         j_sel;
    logic         halt;
    reg_idx_t     rs1;
    reg_idx_t     rs2;
    reg_idx_t     rd;
  } ctrl_t;

endpackage

// File: sim.f
+incdir+hw
hw/rv_types_pkg.sv
hw/fetch_execute_if.sv
hw/control_unit.sv
hw/reg_file.sv
hw/alu.sv
hw/fetch_stage.sv
hw/execute_stage.sv
hw/rv_core_top.sv
test/tb_rv_core.sv

// File: test/tb_rv_core.sv
// testbench for the rv32i core with memory models, program builder, reference model and checks
`timescale 1ns/10ps
`include "rv_consts.svh"

module tb_rv_core;

  logic                CLK;
  logic                arst_n;
  rv_types_pkg::word_t imem_addr, imem_rdata;
  rv_types_pkg::word_t dmem_addr, dmem_wdata, dmem_rdata;
  rv_types_pkg::word_t dmem_word;
  logic [3:0]          dmem_byte_en;
  logic                dmem_ren, dmem_wen, dmem_busy;
  logic                halt, mal_fault;

  // 256 program words, 1 KiB of data bytes
  rv_types_pkg::word_t imem [0:255];
  logic [7:0]          dmem [0:1023];
  logic [7:0]          init_mem [0:1023];
  logic [7:0]          ref_mem [0:1023];

  // expected bus writes, in program order
  rv_types_pkg::word_t exp_addr [$];
  rv_types_pkg::word_t exp_data [$];
  logic [3:0]          exp_be [$];
  int                  exp_faults;

  int prog_len, st_addr, wr_idx, fault_cnt, busy_left;
  bit busy_on, acc_open, watch_idle;

  rv_core_top UUT (
    .CLK          (CLK),
    .arst_n       (arst_n),
    .imem_addr    (imem_addr),
    .imem_rdata   (imem_rdata),
    .dmem_addr    (dmem_addr),
    .dmem_wdata   (dmem_wdata),
    .dmem_byte_en (dmem_byte_en),
    .dmem_ren     (dmem_ren),
    .dmem_wen     (dmem_wen),
    .dmem_rdata   (dmem_rdata),
    .dmem_busy    (dmem_busy),
    .halt         (halt),
    .mal_fault    (mal_fault)
  );

  initial CLK = 1'b0;
  always #2 CLK = ~CLK;

  // both memories answer in the same cycle
  assign imem_rdata = imem[imem_addr[9:2]];
  assign dmem_word  = {dmem[{dmem_addr[9:2], 2'd3}], dmem[{dmem_addr[9:2], 2'd2}],
                       dmem[{dmem_addr[9:2], 2'd1}], dmem[{dmem_addr[9:2], 2'd0}]};
  // read data only valid while a read completes, otherwise the bus shows its inverse
  assign dmem_rdata = (dmem_ren && !dmem_busy) ? dmem_word : ~dmem_word;

  task automatic fail_with(input string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopped on first error");
  endtask

  task automatic check_eq(input string name, input rv_types_pkg::word_t got,
                          input rv_types_pkg::word_t exp);
    if (got !== exp) begin
      fail_with($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  // instruction encoders
  function automatic rv_types_pkg::word_t r_type(input logic [6:0] f7, input logic [2:0] f3,
                                                 input int rd, input int rs1, input int rs2);
    return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], `RV_OP_OP};
  endfunction

  function automatic rv_types_pkg::word_t i_type(input logic [6:0] opc, input int rd,
                                                 input logic [2:0] f3, input int rs1,
                                                 input int imm);
    return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
  endfunction

  function automatic rv_types_pkg::word_t s_type(input logic [2:0] f3, input int rs1,
                                                 input int rs2, input int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3, imm[4:0], `RV_OP_STORE};
  endfunction

  function automatic rv_types_pkg::word_t b_type(input logic [2:0] f3, input int rs1,
                                                 input int rs2, input int off);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], `RV_OP_BRANCH};
  endfunction

  function automatic rv_types_pkg::word_t u_type(input logic [6:0] opc, input int rd,
                                                 input int imm);
    return {imm[19:0], rd[4:0], opc};
  endfunction

  function automatic rv_types_pkg::word_t j_type(input int rd, input int off);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], `RV_OP_JAL};
  endfunction

  task automatic emit(input rv_types_pkg::word_t w);
    imem[prog_len] = w;
    prog_len++;
  endtask

  // each result goes to the next word of the result area
  task automatic store_reg(input int rs);
    emit(s_type(`RV_F3_SW, 0, rs, st_addr));
    st_addr += 4;
  endtask

  task automatic build_program();
    logic [2:0] f3;
    int         imm, rs1, rs2;
    // unused words are nops whose immediate is their own index
    for (int i = 0; i < 256; i++) begin
      imem[i] = i_type(`RV_OP_OPIMM, 0, `RV_F3_ADD, 0, i);
    end
    prog_len = 0;
    st_addr  = 'h200;
    // x1..x8 loaded from random data words
    for (int r = 1; r <= 8; r++) begin
      emit(i_type(`RV_OP_LOAD, r, `RV_F3_LW, 0, 4 * (r - 1)));
    end
    // register-register, k 8 and 9 are sub and sra
    for (int k = 0; k < 10; k++) begin
      f3 = (k == 8) ? `RV_F3_ADD : (k == 9) ? `RV_F3_SR : k[2:0];
      emit(r_type((k >= 8) ? 7'b0100000 : 7'b0000000, f3, 10, 1 + k % 4, 5 + k % 4));
      store_reg(10);
    end
    // register-immediate, k 8 is srai
    for (int k = 0; k < 9; k++) begin
      f3 = (k == 8) ? `RV_F3_SR : k[2:0];
      if (f3 == `RV_F3_SLL || f3 == `RV_F3_SR) begin
        imm = int'($urandom_range(31, 0)) + ((k == 8) ? 'h400 : 0);
      end else begin
        imm = int'($urandom);
      end
      emit(i_type(`RV_OP_OPIMM, 10, f3, 1 + k % 8, imm));
      store_reg(10);
    end
    emit(u_type(`RV_OP_LUI, 10, $urandom));
    store_reg(10);
    emit(u_type(`RV_OP_AUIPC, 10, $urandom));
    store_reg(10);
    // each branch skips its store when taken
    for (int bt = 0; bt < 6; bt++) begin
      for (int p = 0; p < 4; p++) begin
        f3  = (bt < 2) ? bt[2:0] : bt[2:0] + 3'd2;
        rs1 = p + 1;
        rs2 = (p == 1) ? 1 : (p == 2) ? 3 : p + 2;
        emit(b_type(f3, rs1, rs2, 8));
        store_reg(rs1);
      end
    end
    // jal over one store, then its link
    emit(j_type(11, 8));
    store_reg(1);
    store_reg(11);
    // jalr with an odd offset, bit 0 must be dropped
    emit(u_type(`RV_OP_AUIPC, 12, 0));
    emit(i_type(`RV_OP_JALR, 13, 3'b000, 12, 13));
    store_reg(1);
    store_reg(13);
    // auipc past the target exposes an odd pc
    emit(u_type(`RV_OP_AUIPC, 12, 0));
    store_reg(12);
    // sub-word stores at every legal offset
    for (int o = 0; o < 4; o++) begin
      emit(s_type(`RV_F3_SB, 0, 1, 'h3c0 + o));
    end
    emit(s_type(`RV_F3_SH, 0, 2, 'h3d0));
    emit(s_type(`RV_F3_SH, 0, 2, 'h3d2));
    // sub-word loads, results stored back
    for (int o = 0; o < 4; o++) begin
      emit(i_type(`RV_OP_LOAD, 14, `RV_F3_LB, 0, 'h40 + o));
      store_reg(14);
      emit(i_type(`RV_OP_LOAD, 14, `RV_F3_LBU, 0, 'h40 + o));
      store_reg(14);
    end
    for (int o = 0; o < 4; o += 2) begin
      emit(i_type(`RV_OP_LOAD, 14, `RV_F3_LH, 0, 'h40 + o));
      store_reg(14);
      emit(i_type(`RV_OP_LOAD, 14, `RV_F3_LHU, 0, 'h40 + o));
      store_reg(14);
    end
    // misaligned accesses, x15 must keep its marker
    emit(i_type(`RV_OP_OPIMM, 15, `RV_F3_ADD, 0, 'h123));
    for (int o = 1; o < 4; o++) begin
      emit(i_type(`RV_OP_LOAD, 15, `RV_F3_LW, 0, 'h40 + o));
      store_reg(15);
    end
    for (int o = 1; o < 4; o += 2) begin
      emit(i_type(`RV_OP_LOAD, 15, `RV_F3_LH, 0, 'h40 + o));
      store_reg(15);
      emit(s_type(`RV_F3_SH, 0, 1, 'h3e0 + o));
    end
    emit(`RV_HALT_INSN);
  endtask

  // architectural rv32i model, fills the expected write list and fault count
  function automatic void rv_ref();
    rv_types_pkg::word_t x [0:31];
    rv_types_pkg::word_t pc, nxt, insn, a, b, op_b, res, ea, data;
    rv_types_pkg::word_t imm_i, imm_s, imm_b, imm_j;
    logic [2:0]          f3;
    logic [3:0]          be;
    bit                  wr, take;
    int                  ia, steps;
    for (int i = 0; i < 32; i++) begin
      x[i] = '0;
    end
    for (int i = 0; i < 1024; i++) begin
      ref_mem[i] = init_mem[i];
    end
    exp_addr.delete();
    exp_data.delete();
    exp_be.delete();
    exp_faults = 0;
    pc    = `RV_RESET_PC;
    steps = 0;
    while (steps < 1000) begin
      insn = imem[pc[9:2]];
      if (insn == `RV_HALT_INSN) break;
      f3    = insn[14:12];
      a     = x[insn[19:15]];
      b     = x[insn[24:20]];
      imm_i = {{20{insn[31]}}, insn[31:20]};
      imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
      imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
      imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
      nxt   = pc + 32'd4;
      res   = '0;
      wr    = 1'b1;
      case (insn[6:0])
        `RV_OP_LUI:   res = {insn[31:12], 12'h000};
        `RV_OP_AUIPC: res = pc + {insn[31:12], 12'h000};
        `RV_OP_JAL: begin
          res = pc + 32'd4;
          nxt = pc + imm_j;
        end
        `RV_OP_JALR: begin
          res = pc + 32'd4;
          nxt = (a + imm_i) & ~32'd1;
        end
        `RV_OP_BRANCH: begin
          wr = 1'b0;
          case (f3)
            `RV_F3_BEQ:  take = (a == b);
            `RV_F3_BNE:  take = (a != b);
            `RV_F3_BLT:  take = ($signed(a) < $signed(b));
            `RV_F3_BGE:  take = ($signed(a) >= $signed(b));
            `RV_F3_BLTU: take = (a < b);
            default:     take = (a >= b);
          endcase
          if (take) nxt = pc + imm_b;
        end
        `RV_OP_LOAD, `RV_OP_STORE: begin
          ea = a + ((insn[6:0] == `RV_OP_LOAD) ? imm_i : imm_s);
          ia = {22'd0, ea[9:0]};
          wr = 1'b0;
          // halfwords need an even address, words a multiple of four
          if ((f3[1:0] == 2'd1 && ea[0]) || (f3[1:0] == 2'd2 && ea[1:0] != 2'd0)) begin
            exp_faults++;
          end else if (insn[6:0] == `RV_OP_LOAD) begin
            case (f3[1:0])
              2'd0:    res = {{24{ref_mem[ia][7] & ~f3[2]}}, ref_mem[ia]};
              2'd1:    res = {{16{ref_mem[ia + 1][7] & ~f3[2]}}, ref_mem[ia + 1], ref_mem[ia]};
              default: res = {ref_mem[ia + 3], ref_mem[ia + 2], ref_mem[ia + 1], ref_mem[ia]};
            endcase
            wr = 1'b1;
          end else begin
            // data repeated in every lane, byte enables select the target
            case (f3[1:0])
              2'd0: begin
                be   = 4'b0001 << ea[1:0];
                data = {4{b[7:0]}};
              end
              2'd1: begin
                be   = ea[1] ? 4'b1100 : 4'b0011;
                data = {2{b[15:0]}};
              end
              default: begin
                be   = 4'b1111;
                data = b;
              end
            endcase
            for (int i = 0; i < 4; i++) begin
              if (be[i]) ref_mem[{ea[9:2], i[1:0]}] = data[8 * i +: 8];
            end
            exp_addr.push_back(ea);
            exp_be.push_back(be);
            exp_data.push_back(data);
          end
        end
        `RV_OP_OP, `RV_OP_OPIMM: begin
          op_b = (insn[6:0] == `RV_OP_OP) ? b : imm_i;
          case (f3)
            `RV_F3_ADD:  res = (insn[6:0] == `RV_OP_OP && insn[30]) ? a - op_b : a + op_b;
            `RV_F3_SLL:  res = a << op_b[4:0];
            `RV_F3_SLT:  res = ($signed(a) < $signed(op_b)) ? 32'd1 : 32'd0;
            `RV_F3_SLTU: res = (a < op_b) ? 32'd1 : 32'd0;
            `RV_F3_XOR:  res = a ^ op_b;
            `RV_F3_SR: begin
              if (insn[30]) res = $signed(a) >>> op_b[4:0];
              else res = a >> op_b[4:0];
            end
            `RV_F3_OR:   res = a | op_b;
            default:     res = a & op_b;
          endcase
        end
        default: wr = 1'b0;
      endcase
      if (wr && insn[11:7] != 5'd0) x[insn[11:7]] = res;
      pc = nxt;
      steps++;
    end
  endfunction

  // busy for 0 to 3 cycles at the start of each new access
  always @(posedge CLK) begin
    #0.5;
    if ((dmem_ren || dmem_wen) && !acc_open) begin
      acc_open  = 1'b1;
      busy_left = busy_on ? int'($urandom_range(3, 0)) : 0;
    end
    dmem_busy = (dmem_ren || dmem_wen) && (busy_left != 0);
    if (busy_left != 0) busy_left--;
  end

  // mid-cycle monitor, completes writes and compares them in order
  always @(negedge CLK) begin
    if (arst_n) begin
      if (mal_fault) fault_cnt++;
      if ((dmem_ren || dmem_wen) && !dmem_busy) acc_open = 1'b0;
      if (watch_idle && (dmem_ren || dmem_wen)) begin
        fail_with("a data bus strobe was driven after halt");
      end else if (dmem_wen && !dmem_busy) begin
        if (wr_idx >= exp_addr.size()) begin
          fail_with("the core wrote to data memory more often than expected");
        end else begin
          check_eq("dmem_addr", dmem_addr, exp_addr[wr_idx]);
          check_eq("dmem_byte_en", {28'd0, dmem_byte_en}, {28'd0, exp_be[wr_idx]});
          check_eq("dmem_wdata", dmem_wdata, exp_data[wr_idx]);
          for (int i = 0; i < 4; i++) begin
            if (dmem_byte_en[i]) dmem[{dmem_addr[9:2], i[1:0]}] = dmem_wdata[8 * i +: 8];
          end
          wr_idx++;
        end
      end
    end
  end

  task automatic run_program(input bit with_busy);
    int cyc;
    @(posedge CLK);
    #0.5;
    arst_n     = 1'b0;
    watch_idle = 1'b0;
    busy_on    = with_busy;
    acc_open   = 1'b0;
    busy_left  = 0;
    wr_idx     = 0;
    fault_cnt  = 0;
    for (int i = 0; i < 1024; i++) begin
      dmem[i] = init_mem[i];
    end
    repeat (5) @(posedge CLK);
    #0.5;
    arst_n = 1'b1;
    cyc    = 0;
    while (!halt && cyc < 3000) begin
      @(negedge CLK);
      cyc++;
    end
    if (!halt) fail_with("timeout while waiting for halt");
    // the core must stay quiet once halted
    watch_idle = 1'b1;
    repeat (50) @(negedge CLK);
    watch_idle = 1'b0;
    check_eq("halt", {31'd0, halt}, 32'd1);
    check_eq("write count", wr_idx, exp_addr.size());
    check_eq("mal_fault count", fault_cnt, exp_faults);
  endtask

  initial begin
    void'($urandom(32'h19e41f0f));
    arst_n     = 1'b0;
    dmem_busy  = 1'b0;
    busy_on    = 1'b0;
    acc_open   = 1'b0;
    watch_idle = 1'b0;
    busy_left  = 0;
    wr_idx     = 0;
    fault_cnt  = 0;
    for (int i = 0; i < 1024; i++) begin
      init_mem[i] = 8'($urandom);
    end
    build_program();
    rv_ref();
    // same program without and then with back-pressure
    run_program(1'b0);
    run_program(1'b1);
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule
